/* common/avmm_pkg.sv */
// bus widths, command and response structs and response codes shared by the bridge and the RAM
package avmm_pkg;

    // --------------------------------------------------
    // bus widths
    // --------------------------------------------------

    // word address, not byte address
    localparam int addr_width = 10;
    localparam int data_width = 32;
    // one enable per byte lane
    localparam int be_width   = data_width / 8;

    // --------------------------------------------------
    // response codes
    // --------------------------------------------------

    // 2-bit response field encoding
    typedef enum logic [1:0] {
        resp_okay     = 2'b00,
        resp_reserved = 2'b01,
        resp_slverr   = 2'b10,
        resp_decerr   = 2'b11
    } avmm_resp_e;

    // --------------------------------------------------
    // command and response bundles
    // --------------------------------------------------

    // master to slave, 48 bits
    typedef struct packed {
        logic                  read;
        logic                  write;
        logic [addr_width-1:0] address;
        logic [be_width-1:0]   byteenable;
        logic [data_width-1:0] writedata;
    } avmm_cmd_t;

    // slave to master, 36 bits
    // one of the two valids marks a response cycle
    typedef struct packed {
        logic                  readdatavalid;
        logic                  writeresponsevalid;
        avmm_resp_e            response;
        logic [data_width-1:0] readdata;
    } avmm_rsp_t;

endpackage

/* avmm_pipeline_bridge/avmm_pipeline_bridge.sv */
// pipeline bridge that registers the command and response paths between master and slave ports
`timescale 1ns/1ns

module avmm_pipeline_bridge #(
    // 1 registers the command path, 0 passes it through
    parameter int pipeline_command  = 1,
    // 1 registers the response path, 0 passes it through
    parameter int pipeline_response = 1
) (
    input  logic                clk,
    input  logic                reset,

    // upstream side, faces the master
    input  avmm_pkg::avmm_cmd_t s_cmd,
    output logic                s_waitrequest,
    output avmm_pkg::avmm_rsp_t s_rsp,

    // downstream side, faces the slave
    output avmm_pkg::avmm_cmd_t m_cmd,
    input  logic                m_waitrequest,
    input  avmm_pkg::avmm_rsp_t m_rsp
);

    import avmm_pkg::*;

    // --------------------------------------------------
    // command path
    // --------------------------------------------------

    if (pipeline_command == 1) begin : g_cmd_pipe

        // skid stage state
        logic      wr_reg_waitrequest;
        logic      use_reg;
        logic      wait_rise;
        avmm_cmd_t skid_cmd;
        // command presented to the downstream stage
        avmm_cmd_t wr_cmd;

        // downstream stage state
        avmm_cmd_t cmd_reg;
        logic      cmd_busy;
        logic      cmd_waitrequest;

        // master sees waitrequest one cycle late
        assign s_waitrequest = wr_reg_waitrequest;

        // low to high edge of the internal waitrequest
        assign wait_rise = ~wr_reg_waitrequest & cmd_waitrequest;

        // skid register and its select flag
        // the master may still present a command in the cycle
        // where waitrequest rises internally, that one is caught here
        always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
                wr_reg_waitrequest <= 1'b1;
                // start on the skid copy, which is idle after reset,
                // so the first falling waitrequest cannot let the
                // downstream stage load the same command twice
                use_reg            <= 1'b1;
                skid_cmd.read      <= 1'b0;
                skid_cmd.write     <= 1'b0;
            end else begin
                wr_reg_waitrequest <= cmd_waitrequest;

                if (wait_rise) begin
                    skid_cmd <= s_cmd;
                end

                // release the skid copy once downstream takes it
                if (!cmd_waitrequest) begin
                    use_reg <= 1'b0;
                end else if (wait_rise) begin
                    use_reg <= 1'b1;
                end
            end
        end

        // select between live master command and the skid copy
        always_comb begin
            wr_cmd = s_cmd;
            if (use_reg) begin
                wr_cmd = skid_cmd;
            end
        end

        // downstream holds a command
        assign cmd_busy = cmd_reg.read | cmd_reg.write;

        // waitrequest only matters while a command is held
        // an idle stage always looks ready to the skid stage
        assign cmd_waitrequest = m_waitrequest & cmd_busy;

        // command register, reloads whenever not stalled
        always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
                cmd_reg.read  <= 1'b0;
                cmd_reg.write <= 1'b0;
            end else if (!cmd_waitrequest) begin
                cmd_reg <= wr_cmd;
            end
        end

        assign m_cmd = cmd_reg;

    end else begin : g_cmd_pass

        // straight wires, waitrequest unregistered
        assign m_cmd         = s_cmd;
        assign s_waitrequest = m_waitrequest;

    end

    // --------------------------------------------------
    // response path
    // --------------------------------------------------

    if (pipeline_response == 1) begin : g_rsp_pipe

        avmm_rsp_t rsp_reg;

        // valids and code reset, read data just follows
        always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
                rsp_reg.readdatavalid      <= 1'b0;
                rsp_reg.writeresponsevalid <= 1'b0;
                rsp_reg.response           <= resp_okay;
            end else begin
                rsp_reg <= m_rsp;
            end
        end

        assign s_rsp = rsp_reg;

    end else begin : g_rsp_pass

        // no back-pressure on responses, direct path
        assign s_rsp = m_rsp;

    end

endmodule

/* logic/avmm_ram_slave.sv */
// word RAM slave with wait states, byte enables, fixed response latency and range error
`timescale 1ns/1ns

module avmm_ram_slave #(
    // implemented words, the rest of the address range errors
    parameter int mem_words   = 768,
    // waitrequest cycles before a command is accepted
    parameter int wait_states = 2,
    // cycles from acceptance to response, at least 1
    parameter int rsp_latency = 3
) (
    input  logic                clk,
    input  logic                reset,
    input  avmm_pkg::avmm_cmd_t cmd,
    output logic                waitrequest,
    output avmm_pkg::avmm_rsp_t rsp
);

    import avmm_pkg::*;

    // counter wide enough for wait_states, never zero width
    localparam int cnt_width = (wait_states > 0) ? $clog2(wait_states + 1) : 1;

    // --------------------------------------------------
    // signals
    // --------------------------------------------------

    logic [data_width-1:0] mem [mem_words];

    logic                  cmd_valid;
    logic                  accept;
    logic                  in_range;
    logic [cnt_width-1:0]  wait_cnt;
    avmm_rsp_t             next_rsp;

    // stage 0 is newest, last stage drives the port
    avmm_rsp_t             rsp_pipe [rsp_latency];

    // --------------------------------------------------
    // wait state handshake
    // --------------------------------------------------

    assign cmd_valid = cmd.read | cmd.write;

    // stall until the counter reaches wait_states
    // idle slave never asserts waitrequest
    assign waitrequest = cmd_valid & (wait_cnt != cnt_width'(wait_states));
    assign accept      = cmd_valid & ~waitrequest;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wait_cnt <= '0;
        end else if (accept) begin
            // back to zero so the next command waits again
            wait_cnt <= '0;
        end else if (waitrequest) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // --------------------------------------------------
    // RAM access
    // --------------------------------------------------

    // upper part of the address space is unimplemented
    assign in_range = int'(cmd.address) < mem_words;

    // byte lane merge, out of range writes dropped
    always_ff @(posedge clk) begin
        if (accept && cmd.write && in_range) begin
            for (int b = 0; b < be_width; b++) begin
                if (cmd.byteenable[b]) begin
                    mem[cmd.address][8*b +: 8] <= cmd.writedata[8*b +: 8];
                end
            end
        end
    end

    // response built in the accepting cycle
    always_comb begin
        next_rsp                    = '0;
        next_rsp.readdatavalid      = accept & cmd.read;
        next_rsp.writeresponsevalid = accept & cmd.write;
        next_rsp.response           = in_range ? resp_okay : resp_slverr;
        // zero data for writes and for bad reads
        if (cmd.read && in_range) begin
            next_rsp.readdata = mem[cmd.address];
        end
    end

    // --------------------------------------------------
    // response latency pipeline
    // --------------------------------------------------

    // one slot per cycle of latency, so rsp_latency can be in flight
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < rsp_latency; i++) begin
                rsp_pipe[i].readdatavalid      <= 1'b0;
                rsp_pipe[i].writeresponsevalid <= 1'b0;
                rsp_pipe[i].response           <= resp_okay;
            end
        end else begin
            rsp_pipe[0] <= next_rsp;
            for (int i = 1; i < rsp_latency; i++) begin
                rsp_pipe[i] <= rsp_pipe[i-1];
            end
        end
    end

    // in order by construction
    assign rsp = rsp_pipe[rsp_latency-1];

endmodule

/* logic/avmm_bridge_subsystem.sv */
// top level joining the pipeline bridge to the RAM slave behind one upstream port
`timescale 1ns/1ns

module avmm_bridge_subsystem #(
    parameter int pipeline_command  = 1,
    parameter int pipeline_response = 1,
    parameter int mem_words         = 768,
    parameter int wait_states       = 2,
    parameter int rsp_latency       = 3
) (
    input  logic                clk,
    input  logic                reset,
    input  avmm_pkg::avmm_cmd_t s_cmd,
    output logic                s_waitrequest,
    output avmm_pkg::avmm_rsp_t s_rsp
);

    import avmm_pkg::*;

    // bridge to RAM link
    avmm_cmd_t m_cmd;
    logic      m_waitrequest;
    avmm_rsp_t m_rsp;

    avmm_pipeline_bridge #(
        .pipeline_command  (pipeline_command),
        .pipeline_response (pipeline_response)
    ) u_bridge (
        .clk           (clk),
        .reset         (reset),
        .s_cmd         (s_cmd),
        .s_waitrequest (s_waitrequest),
        .s_rsp         (s_rsp),
        .m_cmd         (m_cmd),
        .m_waitrequest (m_waitrequest),
        .m_rsp         (m_rsp)
    );

    avmm_ram_slave #(
        .mem_words   (mem_words),
        .wait_states (wait_states),
        .rsp_latency (rsp_latency)
    ) u_ram (
        .clk         (clk),
        .reset       (reset),
        .cmd         (m_cmd),
        .waitrequest (m_waitrequest),
        .rsp         (m_rsp)
    );

endmodule

/* verification/tb_clock_gen.sv */
// free running testbench clock plus a power-on reset held for a set number of cycles
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int period_ns    = 100,
    parameter int reset_cycles = 4
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk   = 1'b0;
        reset = 1'b0;
        // raise reset after time zero so async flops see a clean edge
        #(period_ns / 10) reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
    end

    always #(period_ns / 2) clk = ~clk;

endmodule

/* verification/avmm_bridge_checker.sv */
// protocol assertions on the bridge ports, attached to every bridge instance with bind
`timescale 1ns/1ns

module avmm_bridge_checker (
    input logic                clk,
    input logic                reset,
    input avmm_pkg::avmm_cmd_t s_cmd,
    input logic                s_waitrequest,
    input avmm_pkg::avmm_rsp_t s_rsp,
    input avmm_pkg::avmm_cmd_t m_cmd
);

    import avmm_pkg::*;

    // failed assertions so far, summed into the final verdict
    int          fail_count = 0;
    // accepted commands still waiting for a response, per kind
    logic [15:0] rd_open;
    logic [15:0] wr_open;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_open <= '0;
            wr_open <= '0;
        end else begin
            rd_open <= rd_open + {15'd0, s_cmd.read & ~s_waitrequest}
                       - {15'd0, s_rsp.readdatavalid};
            wr_open <= wr_open + {15'd0, s_cmd.write & ~s_waitrequest}
                       - {15'd0, s_rsp.writeresponsevalid};
        end
    end

    // --------------------------------------------------
    // upstream command rules
    // --------------------------------------------------

    assert property (@(posedge clk) disable iff (reset) !(s_cmd.read && s_cmd.write))
        else begin
            $error("s_cmd has read and write high in the same cycle");
            fail_count++;
        end

    // a stalled command must not move
    assert property (@(posedge clk) disable iff (reset)
        (s_waitrequest && (s_cmd.read || s_cmd.write)) |=> $stable(s_cmd))
        else begin
            $error("s_cmd changed while s_waitrequest was high");
            fail_count++;
        end

    // downstream idle right after release
    assert property (@(posedge clk) $fell(reset) |-> !m_cmd.read && !m_cmd.write)
        else begin
            $error("m_cmd carries a command in the first cycle after reset");
            fail_count++;
        end

    // --------------------------------------------------
    // responses need an open command of the same kind
    // --------------------------------------------------

    assert property (@(posedge clk) disable iff (reset) s_rsp.readdatavalid |-> rd_open != 0)
        else begin
            $error("readdatavalid with no accepted read outstanding");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (reset)
        s_rsp.writeresponsevalid |-> wr_open != 0)
        else begin
            $error("writeresponsevalid with no accepted write outstanding");
            fail_count++;
        end

endmodule

bind avmm_pipeline_bridge avmm_bridge_checker u_checker (
    .clk           (clk),
    .reset         (reset),
    .s_cmd         (s_cmd),
    .s_waitrequest (s_waitrequest),
    .s_rsp         (s_rsp),
    .m_cmd         (m_cmd)
);

/* verification/avmm_bridge_monitor.sv */
// watches the upstream port, queues expected responses and compares each arriving response
`timescale 1ns/1ns

module avmm_bridge_monitor (
    input  logic                clk,
    input  logic                reset,
    input  logic                s_waitrequest,
    input  avmm_pkg::avmm_rsp_t s_rsp,
    // one push per accepted command
    input  logic                exp_push,
    input  avmm_pkg::avmm_rsp_t exp_rsp,
    output int                  error_count,
    output int                  outstanding
);

    import avmm_pkg::*;

    avmm_rsp_t exp_q [$];
    logic      was_reset;

    initial begin
        error_count = 0;
        outstanding = 0;
        was_reset   = 1'b0;
    end

    task automatic check_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t %s: expected %h, got %h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    always @(posedge clk) begin
        avmm_rsp_t head;

        was_reset <= reset;
        // --------------------------------------------------
        // reset and the first cycle after it
        // --------------------------------------------------
        if (reset || was_reset) begin
            check_field("s_waitrequest", 32'd1, s_waitrequest);
            check_field("s_rsp.readdatavalid", 32'd0, s_rsp.readdatavalid);
            check_field("s_rsp.writeresponsevalid", 32'd0, s_rsp.writeresponsevalid);
        end else if (s_rsp.readdatavalid || s_rsp.writeresponsevalid) begin
            if (exp_q.size() == 0) begin
                $display("%0t: a response arrived with no command outstanding", $time);
                error_count++;
            end else begin
                // in order, so the oldest entry is the match
                head = exp_q.pop_front();
                check_field("s_rsp.readdatavalid", head.readdatavalid, s_rsp.readdatavalid);
                check_field("s_rsp.writeresponsevalid", head.writeresponsevalid,
                            s_rsp.writeresponsevalid);
                check_field("s_rsp.response", head.response, s_rsp.response);
                // read data only means something on reads
                if (head.readdatavalid) begin
                    check_field("s_rsp.readdata", head.readdata, s_rsp.readdata);
                end
            end
        end

        if (exp_push) begin
            exp_q.push_back(exp_rsp);
        end
        outstanding = exp_q.size();
    end

endmodule

/* verification/avmm_bridge_tb.sv */
// testbench top that reads the access vectors, drives the upstream port and prints the verdict
`timescale 1ns/1ns

module avmm_bridge_tb;

    import avmm_pkg::*;

    localparam int pipeline_command  = 1;
    localparam int pipeline_response = 1;
    localparam int mem_words         = 768;
    localparam int wait_states       = 2;
    localparam int rsp_latency       = 3;
    // words per vector line, and room for that many lines
    localparam int vec_fields        = 6;
    localparam int max_vectors       = 64;
    // first commands go out with no gap to load the skid register
    localparam int burst_len         = 8;

    logic        clk;
    logic        reset;
    avmm_cmd_t   s_cmd;
    logic        s_waitrequest;
    avmm_rsp_t   s_rsp;
    logic        exp_push;
    avmm_rsp_t   exp_rsp;
    int          error_count;
    int          outstanding;
    logic [31:0] vec_mem [vec_fields*max_vectors];
    int          num_vectors;
    logic        vectors_loaded;
    logic [31:0] lcg_state;

    tb_clock_gen #(.period_ns(100), .reset_cycles(4)) u_clock_gen (.clk(clk), .reset(reset));

    avmm_bridge_subsystem #(
        .pipeline_command  (pipeline_command),
        .pipeline_response (pipeline_response),
        .mem_words         (mem_words),
        .wait_states       (wait_states),
        .rsp_latency       (rsp_latency)
    ) u_avmm_bridge_subsystem (
        .clk           (clk),
        .reset         (reset),
        .s_cmd         (s_cmd),
        .s_waitrequest (s_waitrequest),
        .s_rsp         (s_rsp)
    );

    avmm_bridge_monitor u_monitor (
        .clk           (clk),
        .reset         (reset),
        .s_waitrequest (s_waitrequest),
        .s_rsp         (s_rsp),
        .exp_push      (exp_push),
        .exp_rsp       (exp_rsp),
        .error_count   (error_count),
        .outstanding   (outstanding)
    );

    // --------------------------------------------------
    // driver helpers
    // --------------------------------------------------

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic idle_cycle();
        s_cmd <= '0;
        @(posedge clk);
        exp_push <= 1'b0;
    endtask

    // present a command, hold it through waitrequest, then hand over the expectation
    task automatic issue_command(input avmm_cmd_t cmd, input avmm_rsp_t expected);
        s_cmd <= cmd;
        @(posedge clk);
        exp_push <= 1'b0;
        while (s_waitrequest) begin
            @(posedge clk);
        end
        exp_push <= 1'b1;
        exp_rsp  <= expected;
    endtask

    initial begin : main
        avmm_cmd_t   cmd;
        avmm_rsp_t   expected;
        logic [31:0] rnd;
        int          base;
        int          total;

        s_cmd          = '0;
        exp_push       = 1'b0;
        exp_rsp        = '0;
        vectors_loaded = 1'b0;
        num_vectors    = 0;
        lcg_state      = 32'hd27254f0;
        for (int i = 0; i < vec_fields * max_vectors; i++) begin
            vec_mem[i] = '0;
        end
        $readmemh("verification/avmm_vectors.txt", vec_mem);
        // list ends at the first line without a read or write kind
        while (num_vectors < max_vectors && (vec_mem[vec_fields*num_vectors] == 1 ||
               vec_mem[vec_fields*num_vectors] == 2)) begin
            num_vectors++;
        end
        vectors_loaded = 1'b1;

        if (num_vectors == 0) begin
            $display("no access vectors could be read from the vector file");
            $display("Verification failed");
            $finish;
        end else begin
            // the real release, not the X to 0 step at time zero
            wait (reset === 1'b1);
            @(negedge reset);
            @(posedge clk);
            for (int v = 0; v < num_vectors; v++) begin
                base                        = vec_fields * v;
                cmd                         = '0;
                cmd.read                    = vec_mem[base] == 1;
                cmd.write                   = vec_mem[base] == 2;
                cmd.address                 = vec_mem[base+1][addr_width-1:0];
                cmd.byteenable              = vec_mem[base+2][be_width-1:0];
                cmd.writedata               = vec_mem[base+3];
                expected                    = '0;
                expected.readdatavalid      = cmd.read;
                expected.writeresponsevalid = cmd.write;
                expected.readdata           = vec_mem[base+4];
                expected.response           = avmm_resp_e'(vec_mem[base+5][1:0]);
                if (v >= burst_len) begin
                    rnd = next_random();
                    repeat (rnd[17:16]) idle_cycle();
                end
                issue_command(cmd, expected);
            end
            idle_cycle();
            @(posedge clk);
            wait (outstanding == 0);
            // late duplicates would land in this window
            repeat (wait_states + rsp_latency + 4) @(posedge clk);
            total = error_count + u_avmm_bridge_subsystem.u_bridge.u_checker.fail_count;
            $display("errors: %0d response, %0d assertion, %0d total", error_count,
                     u_avmm_bridge_subsystem.u_bridge.u_checker.fail_count, total);
            if (total == 0) begin
                $display("Verification passed");
            end else begin
                $display("Verification failed");
            end
            $finish;
        end
    end

    // watchdog budget scales with the vector count
    initial begin : watchdog
        int limit;

        wait (vectors_loaded === 1'b1);
        limit = num_vectors * (wait_states + rsp_latency + 8) + 100;
        repeat (limit) @(posedge clk);
        $display("timeout after %0d cycles, %0d expected responses never arrived",
                 limit, outstanding);
        $display("Verification failed");
        $finish;
    end

endmodule

/* avmm_bridge_subsystem.f */
common/avmm_pkg.sv
avmm_pipeline_bridge/avmm_pipeline_bridge.sv
logic/avmm_ram_slave.sv
logic/avmm_bridge_subsystem.sv
verification/tb_clock_gen.sv
verification/avmm_bridge_checker.sv
verification/avmm_bridge_monitor.sv
verification/avmm_bridge_tb.sv

/* Bender.yml */
package:
  name: avmm_bridge_subsystem

sources:
  # shared package first, then the RTL from the leaves up
  - common/avmm_pkg.sv
  - avmm_pipeline_bridge/avmm_pipeline_bridge.sv
  - logic/avmm_ram_slave.sv
  - logic/avmm_bridge_subsystem.sv
  # testbench, top module avmm_bridge_tb
  - target: simulation
    files:
      - verification/tb_clock_gen.sv
      - verification/avmm_bridge_checker.sv
      - verification/avmm_bridge_monitor.sv
      - verification/avmm_bridge_tb.sv

/* verification/avmm_vectors.txt */
// kind (1 read, 2 write), word address, byte enables, write data, expected read data, response
// response 0 is okay and 2 is slave error; the read data column is zero for writes
2 004 f 11223344 00000000 0
2 005 f a5a5a5a5 00000000 0
2 006 f 0badf00d 00000000 0
2 2ff f cafebabe 00000000 0
1 004 f 00000000 11223344 0
1 005 f 00000000 a5a5a5a5 0
1 006 f 00000000 0badf00d 0
1 2ff f 00000000 cafebabe 0
2 004 3 deadbeef 00000000 0
2 005 c 12345678 00000000 0
2 006 5 ffeeddcc 00000000 0
1 004 f 00000000 1122beef 0
1 005 f 00000000 1234a5a5 0
1 006 f 00000000 0beef0cc 0
2 300 f 55555555 00000000 2
2 3ff f 66666666 00000000 2
1 3ff f 00000000 00000000 2
1 300 f 00000000 00000000 2
1 2ff f 00000000 cafebabe 0
